/* rom_defines.svh */
`ifndef ROM_DEFINES_SVH
`define ROM_DEFINES_SVH

// one rotation of the shared SDRAM port, counted in cen12 steps
`define ROM_SLOTS 16

// default SDRAM word offsets per graphics region
// main code sits at 0, below all of these
`define CHAR_BASE 22'h18000 // 32 kB char tiles
`define MAP1_BASE 22'h1C000 // scroll 1 tile map
`define MAP2_BASE 22'h20000 // scroll 2 tile map
`define SCR1_BASE 22'h24000 // 256 kB scroll 1 tiles
`define SCR2_BASE 22'h44000 // 64 kB scroll 2 tiles

// horizontal sizes, in pixels
`define H_TOTAL   384
`define H_VISIBLE 256

// vertical sizes, in lines
`define V_TOTAL   264
`define V_VISIBLE 224

`endif

/* rom_pkg.sv */
package rom_pkg;

    // word address into the 16-bit SDRAM
    typedef logic [21:0] sdram_addr_t;

    // one word as read back from SDRAM
    typedef logic [15:0] rom_word_t;

    // main CPU sees bytes only
    typedef logic [7:0] cpu_byte_t;

    // rotation step, {h[2:0], hsub}
    typedef logic [3:0] slot_t;

    // region register index
    // 0 char, 1 map1, 2 map2, 3 scr1, 4 scr2, rest unused
    typedef logic [2:0] region_sel_t;

    // pixel counter, wraps at H_TOTAL
    typedef logic [8:0] hcount_t;

    // line counter, wraps at V_TOTAL
    typedef logic [8:0] vcount_t;

endpackage

/* video_timing.sv */
`timescale 1ns/1ps
`include "rom_defines.svh"

module video_timing (
    input  logic             clk,
    input  logic             rst,
    output logic             cen12, // clk/2 pixel enable
    output logic             hsub,  // half-pixel phase
    output rom_pkg::hcount_t h,
    output rom_pkg::vcount_t v,
    output logic             lhbl,  // high while h visible
    output logic             lvbl   // high while v visible
);

    localparam rom_pkg::hcount_t H_LAST = rom_pkg::hcount_t'(`H_TOTAL - 1);
    localparam rom_pkg::vcount_t V_LAST = rom_pkg::vcount_t'(`V_TOTAL - 1);

    logic line_end; // last sub-step of the last pixel

    // clk divider, high on every second clk
    always_ff @(posedge clk) begin
        if (rst) begin
            cen12 <= 1'b0;
        end else begin
            cen12 <= ~cen12;
        end
    end

    // two cen12 steps per pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            hsub <= 1'b0;
        end else if (cen12) begin
            hsub <= ~hsub;
        end
    end

    assign line_end = cen12 && hsub && (h == H_LAST);

    // pixel counter steps when hsub goes back to 0
    always_ff @(posedge clk) begin
        if (rst) begin
            h <= '0;
        end else if (cen12 && hsub) begin
            h <= (h == H_LAST) ? '0 : h + 1'b1; // wrap at end of line
        end
    end

    // line counter
    always_ff @(posedge clk) begin
        if (rst) begin
            v <= '0;
        end else if (line_end) begin
            v <= (v == V_LAST) ? '0 : v + 1'b1;
        end
    end

    // visible area starts at 0 on both axes
    assign lhbl = (h < rom_pkg::hcount_t'(`H_VISIBLE));
    assign lvbl = (v < rom_pkg::vcount_t'(`V_VISIBLE));

endmodule

/* rom_region_cfg.sv */
`timescale 1ns/1ps
`include "rom_defines.svh"

module rom_region_cfg (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cfg_we,   // one clk write strobe
    input  rom_pkg::region_sel_t cfg_sel,
    input  rom_pkg::sdram_addr_t cfg_data,
    output rom_pkg::sdram_addr_t char_base,
    output rom_pkg::sdram_addr_t map1_base,
    output rom_pkg::sdram_addr_t map2_base,
    output rom_pkg::sdram_addr_t scr1_base,
    output rom_pkg::sdram_addr_t scr2_base
);

    // region offsets, visible to the arbiter the clk after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            char_base <= `CHAR_BASE;
            map1_base <= `MAP1_BASE;
            map2_base <= `MAP2_BASE;
            scr1_base <= `SCR1_BASE;
            scr2_base <= `SCR2_BASE;
        end else if (cfg_we) begin
            case (cfg_sel)
                3'd0: begin
                    char_base <= cfg_data;
                end
                3'd1: begin
                    map1_base <= cfg_data;
                end
                3'd2: begin
                    map2_base <= cfg_data;
                end
                3'd3: begin
                    scr1_base <= cfg_data;
                end
                3'd4: begin
                    scr2_base <= cfg_data;
                end
                // 5..7 decode to nothing
                default: begin
                end
            endcase
        end
    end

endmodule

/* rom_slot_arbiter.sv */
`timescale 1ns/1ps

module rom_slot_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen12,
    input  logic                 hsub,
    input  logic [2:0]           h_low,       // h[2:0]
    input  logic                 downloading, // ROM load in progress
    input  logic                 loop_rst,
    input  logic [17:0]          main_addr,   // byte address
    input  logic [13:0]          char_addr,
    input  logic [13:0]          map1_addr,
    input  logic [13:0]          map2_addr,
    input  logic [16:0]          scr1_addr,
    input  logic [14:0]          scr2_addr,
    input  rom_pkg::sdram_addr_t char_base,
    input  rom_pkg::sdram_addr_t map1_base,
    input  rom_pkg::sdram_addr_t map2_base,
    input  rom_pkg::sdram_addr_t scr1_base,
    input  rom_pkg::sdram_addr_t scr2_base,
    input  rom_pkg::rom_word_t   data_read,
    output logic                 sdram_re,    // any edge is a new request
    output rom_pkg::sdram_addr_t sdram_addr,
    output rom_pkg::cpu_byte_t   main_dout,
    output rom_pkg::rom_word_t   char_dout,
    output rom_pkg::rom_word_t   map1_dout,
    output rom_pkg::rom_word_t   map2_dout,
    output rom_pkg::rom_word_t   scr1_dout,
    output rom_pkg::rom_word_t   scr2_dout,
    output logic                 ready
);

    rom_pkg::slot_t slot;      // step presenting an address now
    rom_pkg::slot_t slot_last; // step whose word returns now
    logic           hold;      // port parked, everything zero
    logic           main_lsb;  // byte select for the pending main read
    logic [3:0]     ready_sr;  // ready delay after release

    assign slot = {h_low, hsub};
    assign hold = rst || loop_rst || downloading;

    // request toggle, one per cen12 step while running
    always_ff @(posedge clk) begin
        if (hold) begin
            sdram_re <= 1'b0;
        end else if (cen12) begin
            sdram_re <= ~sdram_re;
        end
    end

    // main byte select travels with its address
    always_ff @(posedge clk) begin
        if (cen12 && slot[1:0] == 2'b01) begin
            main_lsb <= main_addr[0];
        end
    end

    always_ff @(posedge clk) begin
        if (hold) begin
            sdram_addr <= '0;
            slot_last  <= '0; // slot 0 is idle, nothing captured
            main_dout  <= '0;
            char_dout  <= '0;
            map1_dout  <= '0;
            map2_dout  <= '0;
            scr1_dout  <= '0;
            scr2_dout  <= '0;
            ready_sr   <= '0;
            ready      <= 1'b0;
        end else if (cen12) begin
            {ready, ready_sr} <= {ready_sr, 1'b1}; // high on 5th step
            slot_last <= slot;

            // word for the address of the previous step
            casez (slot_last)
                4'b??01: main_dout <= main_lsb ? data_read[7:0] : data_read[15:8];
                4'b0010: char_dout <= data_read;
                4'b1010: map1_dout <= data_read;
                4'b1110: map2_dout <= data_read;
                4'b0011, 4'b?100: scr1_dout <= data_read; // 3, 4, 12
                4'b?111, 4'b1011: scr2_dout <= data_read; // 7, 11, 15
                default: begin
                end
            endcase

            // next address, idle slots 0, 6, 8 keep the old one
            casez (slot)
                4'b??01: sdram_addr <= {5'd0, main_addr[17:1]}; // main at base 0
                4'b0010: sdram_addr <= char_base + {8'd0, char_addr};
                4'b1010: sdram_addr <= map1_base + {8'd0, map1_addr};
                4'b1110: sdram_addr <= map2_base + {8'd0, map2_addr};
                4'b0011, 4'b?100: sdram_addr <= scr1_base + {5'd0, scr1_addr};
                4'b?111, 4'b1011: sdram_addr <= scr2_base + {7'd0, scr2_addr};
                default: begin
                end
            endcase
        end
    end

endmodule

/* rom_subsystem.sv */
`timescale 1ns/1ps

module rom_subsystem (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 downloading,
    input  logic                 loop_rst,
    input  logic [17:0]          main_addr,
    input  logic [13:0]          char_addr,
    input  logic [13:0]          map1_addr,
    input  logic [13:0]          map2_addr,
    input  logic [16:0]          scr1_addr,
    input  logic [14:0]          scr2_addr,
    input  logic                 cfg_we,
    input  rom_pkg::region_sel_t cfg_sel,
    input  rom_pkg::sdram_addr_t cfg_data,
    input  rom_pkg::rom_word_t   data_read,
    output logic                 sdram_re,
    output rom_pkg::sdram_addr_t sdram_addr,
    output rom_pkg::cpu_byte_t   main_dout,
    output rom_pkg::rom_word_t   char_dout,
    output rom_pkg::rom_word_t   map1_dout,
    output rom_pkg::rom_word_t   map2_dout,
    output rom_pkg::rom_word_t   scr1_dout,
    output rom_pkg::rom_word_t   scr2_dout,
    output logic                 ready,
    output rom_pkg::hcount_t     h,
    output rom_pkg::vcount_t     v,
    output logic                 lhbl,
    output logic                 lvbl
);

    logic                 cen12;
    logic                 hsub;
    rom_pkg::sdram_addr_t char_base;
    rom_pkg::sdram_addr_t map1_base;
    rom_pkg::sdram_addr_t map2_base;
    rom_pkg::sdram_addr_t scr1_base;
    rom_pkg::sdram_addr_t scr2_base;

    video_timing i_video_timing (
        .clk   (clk),
        .rst   (rst),
        .cen12 (cen12),
        .hsub  (hsub),
        .h     (h),
        .v     (v),
        .lhbl  (lhbl),
        .lvbl  (lvbl)
    );

    rom_region_cfg i_rom_region_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_data  (cfg_data),
        .char_base (char_base),
        .map1_base (map1_base),
        .map2_base (map2_base),
        .scr1_base (scr1_base),
        .scr2_base (scr2_base)
    );

    // slot follows the low pixel bits
    rom_slot_arbiter i_rom_slot_arbiter (
        .clk         (clk),
        .rst         (rst),
        .cen12       (cen12),
        .hsub        (hsub),
        .h_low       (h[2:0]),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .main_addr   (main_addr),
        .char_addr   (char_addr),
        .map1_addr   (map1_addr),
        .map2_addr   (map2_addr),
        .scr1_addr   (scr1_addr),
        .scr2_addr   (scr2_addr),
        .char_base   (char_base),
        .map1_base   (map1_base),
        .map2_base   (map2_base),
        .scr1_base   (scr1_base),
        .scr2_base   (scr2_base),
        .data_read   (data_read),
        .sdram_re    (sdram_re),
        .sdram_addr  (sdram_addr),
        .main_dout   (main_dout),
        .char_dout   (char_dout),
        .map1_dout   (map1_dout),
        .map2_dout   (map2_dout),
        .scr1_dout   (scr1_dout),
        .scr2_dout   (scr2_dout),
        .ready       (ready)
    );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held for 16 cycles, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* rom_subsystem_tb.sv */
`timescale 1ns/1ps
`include "rom_defines.svh"

module rom_subsystem_tb;

    localparam int ROTATION_CLKS = 2 * `ROM_SLOTS;  // cen12 is every second clk
    localparam int PIXEL_CLKS    = 4;               // two cen12 steps per pixel
    localparam int LINE_CLKS     = PIXEL_CLKS * `H_TOTAL;
    localparam int FRAME_CLKS    = LINE_CLKS * `V_TOTAL;
    localparam int READY_LIMIT   = 10;              // 5 cen12 steps
    localparam int HOLD_CHECKS   = 48;
    localparam int RESET_LEN     = 16 + READY_LIMIT + 2;
    localparam int FETCH_LEN     = 2 * ROTATION_CLKS + 4;
    localparam int MAIN_LEN      = 2 * FETCH_LEN;
    localparam int CFG_LEN       = 8 + FETCH_LEN;
    localparam int HOLD_LEN      = 2 * (4 + HOLD_CHECKS + READY_LIMIT + FETCH_LEN); // two sources
    localparam int BLANK_LEN     = 3 * LINE_CLKS;  // worst case wait for a rise, then a line
    localparam int FRAME_LEN     = 3 * FRAME_CLKS;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + FETCH_LEN + MAIN_LEN + CFG_LEN + HOLD_LEN + BLANK_LEN + FRAME_LEN);

    logic                 clk;
    logic                 rst;
    logic                 downloading;
    logic                 loop_rst;
    logic [17:0]          main_addr;
    logic [13:0]          char_addr;
    logic [13:0]          map1_addr;
    logic [13:0]          map2_addr;
    logic [16:0]          scr1_addr;
    logic [14:0]          scr2_addr;
    logic                 cfg_we;
    rom_pkg::region_sel_t cfg_sel;
    rom_pkg::sdram_addr_t cfg_data;
    rom_pkg::rom_word_t   data_read = '0;
    logic                 sdram_re;
    rom_pkg::sdram_addr_t sdram_addr;
    rom_pkg::cpu_byte_t   main_dout;
    rom_pkg::rom_word_t   char_dout;
    rom_pkg::rom_word_t   map1_dout;
    rom_pkg::rom_word_t   map2_dout;
    rom_pkg::rom_word_t   scr1_dout;
    rom_pkg::rom_word_t   scr2_dout;
    logic                 ready;
    rom_pkg::hcount_t     h;
    rom_pkg::vcount_t     v;
    logic                 lhbl;
    logic                 lvbl;

    // region offsets as the testbench expects them
    rom_pkg::sdram_addr_t exp_char_base = `CHAR_BASE;
    rom_pkg::sdram_addr_t exp_map1_base = `MAP1_BASE;
    rom_pkg::sdram_addr_t exp_map2_base = `MAP2_BASE;
    rom_pkg::sdram_addr_t exp_scr1_base = `SCR1_BASE;
    rom_pkg::sdram_addr_t exp_scr2_base = `SCR2_BASE;

    logic [31:0] rng_state = 32'd82; // xorshift seed
    int          errors = 0;
    int          failed_tests = 0;
    int          cycle_count = 0;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    rom_subsystem i_rom_subsystem (
        .clk(clk), .rst(rst), .downloading(downloading), .loop_rst(loop_rst),
        .main_addr(main_addr), .char_addr(char_addr), .map1_addr(map1_addr),
        .map2_addr(map2_addr), .scr1_addr(scr1_addr), .scr2_addr(scr2_addr),
        .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_data(cfg_data), .data_read(data_read),
        .sdram_re(sdram_re), .sdram_addr(sdram_addr), .main_dout(main_dout),
        .char_dout(char_dout), .map1_dout(map1_dout), .map2_dout(map2_dout),
        .scr1_dout(scr1_dout), .scr2_dout(scr2_dout), .ready(ready),
        .h(h), .v(v), .lhbl(lhbl), .lvbl(lvbl)
    );

    // memory contents: low 16 bits xor upper six at the top
    function automatic rom_pkg::rom_word_t model_word(input rom_pkg::sdram_addr_t a);
        return a[15:0] ^ {a[21:16], 10'd0};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // registered read, answers well inside one cen12 step
    always @(posedge clk) begin
        data_read <= model_word(sdram_addr);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clk cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic expect_word(input string name, input rom_pkg::rom_word_t got,
                               input rom_pkg::rom_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_byte(input string name, input rom_pkg::cpu_byte_t got,
                               input rom_pkg::cpu_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_addr(input string name, input rom_pkg::sdram_addr_t got,
                               input rom_pkg::sdram_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_hpos(input string name, input rom_pkg::hcount_t got,
                               input rom_pkg::hcount_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_vpos(input string name, input rom_pkg::vcount_t got,
                               input rom_pkg::vcount_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expect_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // idle port, all zero
    task automatic check_zero_state;
        expect_addr("sdram_addr", sdram_addr, '0);
        expect_bit("sdram_re", sdram_re, 1'b0);
        expect_bit("ready", ready, 1'b0);
        expect_byte("main_dout", main_dout, '0);
        expect_word("char_dout", char_dout, '0);
        expect_word("map1_dout", map1_dout, '0);
        expect_word("map2_dout", map2_dout, '0);
        expect_word("scr1_dout", scr1_dout, '0);
        expect_word("scr2_dout", scr2_dout, '0);
    endtask

    // call at the negedge right after the release edge
    task automatic wait_for_ready(input string what);
        int cycles;
        cycles = 0;
        while (!ready && cycles <= READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ready || cycles > READY_LIMIT) begin
            errors++;
            $display("ready did not rise within %0d clk cycles after %s", READY_LIMIT, what);
        end
    endtask

    task automatic check_all_douts;
        rom_pkg::rom_word_t main_word;
        main_word = model_word({5'd0, main_addr[17:1]});
        expect_byte("main_dout", main_dout, main_addr[0] ? main_word[7:0] : main_word[15:8]);
        expect_word("char_dout", char_dout, model_word(exp_char_base + {8'd0, char_addr}));
        expect_word("map1_dout", map1_dout, model_word(exp_map1_base + {8'd0, map1_addr}));
        expect_word("map2_dout", map2_dout, model_word(exp_map2_base + {8'd0, map2_addr}));
        expect_word("scr1_dout", scr1_dout, model_word(exp_scr1_base + {5'd0, scr1_addr}));
        expect_word("scr2_dout", scr2_dout, model_word(exp_scr2_base + {7'd0, scr2_addr}));
    endtask

    task automatic settle_rotations(input int n);
        repeat (n * ROTATION_CLKS) @(posedge clk);
        @(negedge clk); // sample away from the edge
    endtask

    task automatic draw_addresses;
        @(posedge clk);
        rng_state = xorshift32(rng_state);
        main_addr <= rng_state[17:0];
        char_addr <= rng_state[31:18];
        rng_state = xorshift32(rng_state);
        map1_addr <= rng_state[13:0];
        map2_addr <= rng_state[27:14];
        rng_state = xorshift32(rng_state);
        scr1_addr <= rng_state[16:0];
        scr2_addr <= rng_state[31:17];
    endtask

    task automatic write_region(input rom_pkg::region_sel_t sel,
                                input rom_pkg::sdram_addr_t data);
        @(posedge clk);
        cfg_we   <= 1'b1;
        cfg_sel  <= sel;
        cfg_data <= data;
        @(posedge clk);
        cfg_we   <= 1'b0; // one clk strobe
    endtask

    // park the port with one hold source, release it, then wait for the refill
    task automatic hold_and_release(input logic by_loop, input string what);
        @(posedge clk);
        if (by_loop) begin
            loop_rst <= 1'b1;
        end else begin
            downloading <= 1'b1;
        end
        @(posedge clk); // arbiter parks on this edge
        repeat (HOLD_CHECKS) begin
            @(negedge clk);
            check_zero_state();
        end
        @(posedge clk);
        loop_rst    <= 1'b0;
        downloading <= 1'b0;
        @(negedge clk);
        wait_for_ready(what);
        settle_rotations(2);
        check_all_douts(); // refilled
    endtask

    // pick the line or the frame blanking level
    function automatic logic blank_level(input logic frame);
        return frame ? lvbl : lhbl;
    endfunction

    // clk cycles high, and rise to rise, sampled at negedges
    task automatic measure_blanking(input logic frame, output int high_cycles,
                                    output int period);
        logic prev;
        high_cycles = 0;
        period = 0;
        @(negedge clk);
        prev = blank_level(frame);
        @(negedge clk);
        while (!(blank_level(frame) && !prev)) begin // look for a rise
            prev = blank_level(frame);
            @(negedge clk);
        end
        expect_hpos("h at blanking rise", h, '0); // visible area starts at pixel 0
        if (frame) begin
            expect_vpos("v at lvbl rise", v, '0);
        end
        while (blank_level(frame)) begin
            high_cycles++;
            period++;
            @(negedge clk);
        end
        while (!blank_level(frame)) begin
            period++;
            @(negedge clk);
        end
    endtask

    task automatic reset_release;
        int err0;
        err0 = errors;
        @(negedge clk);
        while (rst) @(negedge clk);
        check_zero_state(); // first negedge after release, still held
        wait_for_ready("reset release");
        finish_test("reset release", err0);
    endtask

    task automatic random_fetch;
        int   err0;
        logic re_before;
        err0 = errors;
        draw_addresses();
        settle_rotations(2);
        check_all_douts();
        re_before = sdram_re;
        repeat (2) @(negedge clk);
        expect_bit("sdram_re", sdram_re, ~re_before); // one toggle per cen12 step
        finish_test("random fetch", err0);
    endtask

    task automatic main_byte_select;
        int err0;
        err0 = errors;
        draw_addresses();
        @(posedge clk);
        main_addr[0] <= 1'b0; // upper byte
        settle_rotations(2);
        check_all_douts();
        @(posedge clk);
        main_addr[0] <= 1'b1; // lower byte
        settle_rotations(2);
        check_all_douts();
        finish_test("main byte select", err0);
    endtask

    task automatic region_rewrite;
        int err0;
        rom_pkg::sdram_addr_t new_map1;
        rom_pkg::sdram_addr_t new_scr2;
        err0 = errors;
        rng_state = xorshift32(rng_state);
        new_map1 = rng_state[21:0];
        rng_state = xorshift32(rng_state);
        new_scr2 = rng_state[21:0];
        write_region(3'd1, new_map1);
        write_region(3'd4, new_scr2);
        write_region(3'd6, 22'h3FFFFF); // unused index, no register
        exp_map1_base = new_map1;
        exp_scr2_base = new_scr2;
        settle_rotations(2);
        check_all_douts();
        finish_test("region rewrite", err0);
    endtask

    task automatic download_hold;
        int err0;
        err0 = errors;
        hold_and_release(1'b0, "download release");
        hold_and_release(1'b1, "loop_rst release");
        finish_test("download and loop_rst hold", err0);
    endtask

    task automatic line_blanking;
        int err0;
        int high_cycles;
        int period;
        err0 = errors;
        measure_blanking(1'b0, high_cycles, period);
        expect_count("lhbl high cycles", high_cycles, PIXEL_CLKS * `H_VISIBLE);
        expect_count("lhbl period", period, LINE_CLKS);
        finish_test("line blanking", err0);
    endtask

    task automatic frame_blanking;
        int err0;
        int high_cycles;
        int period;
        err0 = errors;
        measure_blanking(1'b1, high_cycles, period);
        expect_count("lvbl high cycles", high_cycles, LINE_CLKS * `V_VISIBLE);
        expect_count("lvbl period", period, FRAME_CLKS);
        finish_test("frame blanking", err0);
    endtask

    initial begin
        downloading <= 1'b0;
        loop_rst    <= 1'b0;
        main_addr   <= '0;
        char_addr   <= '0;
        map1_addr   <= '0;
        map2_addr   <= '0;
        scr1_addr   <= '0;
        scr2_addr   <= '0;
        cfg_we      <= 1'b0;
        cfg_sel     <= '0;
        cfg_data    <= '0;

        reset_release();
        random_fetch();
        main_byte_select();
        region_rewrite();
        download_hold();
        line_blanking();
        frame_blanking();

        $display("tests 7, failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0 && failed_tests == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
rom_pkg.sv
video_timing.sv
rom_region_cfg.sv
rom_slot_arbiter.sv
rom_subsystem.sv
tb_clock.sv
rom_subsystem_tb.sv
